//--- common/isa_pkg.sv
package isa_pkg;

  localparam int XLEN = 32;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // same word seen as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
    } i;
  } instr_u;

  localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013; // addi x0,x0,0

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

  typedef struct packed {
    logic [isa_pkg::XLEN-1:0] pc;
    isa_pkg::instr_u          instr;
  } if_id_t;

  typedef struct packed {
    logic [isa_pkg::XLEN-1:0] opr_a;
    logic [isa_pkg::XLEN-1:0] opr_b;
    logic [isa_pkg::XLEN-1:0] store_data;
    isa_pkg::alu_op_e         alu_op;
    logic [4:0]               rd;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
    logic                     link;
    logic [isa_pkg::XLEN-1:0] link_pc;
  } id_ex_t;

  typedef struct packed {
    logic [isa_pkg::XLEN-1:0] result;
    logic [isa_pkg::XLEN-1:0] store_data;
    logic [4:0]               rd;
    logic                     reg_write;
    logic                     mem_read;
    logic                     mem_write;
  } ex_mem_t;

  typedef struct packed {
    logic [4:0]               rd;
    logic [isa_pkg::XLEN-1:0] data;
    logic                     reg_write;
  } mem_wb_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_EX   = 2'd1,
    FWD_MEM  = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    logic [4:0]               rd;
    logic [isa_pkg::XLEN-1:0] data;
  } retire_t;

endpackage

//--- rtl/hazard_ctrl.sv
module hazard_ctrl (
  input  logic [4:0]          rs1_i,
  input  logic [4:0]          rs2_i,
  input  logic [4:0]          ex_rd_i,
  input  logic                ex_reg_write_i,
  input  logic                ex_mem_read_i,
  input  logic [4:0]          mem_rd_i,
  input  logic                mem_reg_write_i,
  input  logic                branch_taken_i,
  input  logic                is_jump_i,
  output pipe_pkg::fwd_sel_e  fwd_a_o,
  output pipe_pkg::fwd_sel_e  fwd_b_o,
  output logic                stall_o,
  output logic                flush_o,
  output logic                pc_redirect_o
);

  logic ex_valid, mem_valid;

  // a producer writing x0 never forwards
  assign ex_valid  = ex_reg_write_i && ex_rd_i != 5'd0;
  assign mem_valid = mem_reg_write_i && mem_rd_i != 5'd0;

  always_comb begin
    fwd_a_o = pipe_pkg::FWD_NONE;
    if (ex_valid && ex_rd_i == rs1_i)
      fwd_a_o = pipe_pkg::FWD_EX;  // youngest wins
    else if (mem_valid && mem_rd_i == rs1_i)
      fwd_a_o = pipe_pkg::FWD_MEM;
  end

  always_comb begin
    fwd_b_o = pipe_pkg::FWD_NONE;
    if (ex_valid && ex_rd_i == rs2_i)
      fwd_b_o = pipe_pkg::FWD_EX;
    else if (mem_valid && mem_rd_i == rs2_i)
      fwd_b_o = pipe_pkg::FWD_MEM;
  end

  // load result not ready until mem
  assign stall_o = ex_mem_read_i && ex_valid && (ex_rd_i == rs1_i || ex_rd_i == rs2_i);

  assign flush_o       = (branch_taken_i || is_jump_i) && !stall_o;
  assign pc_redirect_o = flush_o;

endmodule

//--- rtl/fetch_unit.sv
module fetch_unit #(
  parameter int IMEM_DEPTH = 64
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          start_i,
  input  logic                          imem_we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
  input  logic [isa_pkg::XLEN-1:0]      imem_data_i,
  input  logic                          stall_i,
  input  logic                          flush_i,
  input  logic                          pc_redirect_i,
  input  logic [isa_pkg::XLEN-1:0]      target_i,
  output pipe_pkg::if_id_t              if_id_o
);

  localparam int AW = $clog2(IMEM_DEPTH);

  logic [isa_pkg::XLEN-1:0] imem [IMEM_DEPTH];
  logic [isa_pkg::XLEN-1:0] pc;
  logic                     running;

  always_ff @(posedge clk_i) begin
    if (imem_we_i)
      imem[imem_addr_i] <= imem_data_i;  // program load port
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      running <= 1'b0;
    else if (start_i)
      running <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)
      pc <= '0;
    else if (running && !stall_i)
      pc <= pc_redirect_i ? target_i : pc + 32'd4;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if_id_o.pc    <= '0;
      if_id_o.instr <= isa_pkg::NOP_WORD;
    end else if (!stall_i) begin
      if_id_o.pc    <= pc;
      // squash the wrong-path word
      if_id_o.instr <= (running && !flush_i) ? imem[pc[AW+1:2]] : isa_pkg::NOP_WORD;
    end
  end

endmodule

//--- rtl/decode_unit.sv
module decode_unit (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  pipe_pkg::if_id_t         if_id_i,
  input  pipe_pkg::mem_wb_t        wb_i,
  input  logic [isa_pkg::XLEN-1:0] ex_fwd_i,
  input  logic [isa_pkg::XLEN-1:0] mem_fwd_i,
  input  pipe_pkg::fwd_sel_e       fwd_a_i,
  input  pipe_pkg::fwd_sel_e       fwd_b_i,
  input  logic                     stall_i,
  output logic [4:0]               rs1_o,
  output logic [4:0]               rs2_o,
  output logic                     branch_taken_o,
  output logic                     is_jump_o,
  output logic [isa_pkg::XLEN-1:0] target_o,
  output pipe_pkg::id_ex_t         id_ex_o
);

  logic [isa_pkg::XLEN-1:0] rf [1:31];
  logic [isa_pkg::XLEN-1:0] rs1_val, rs2_val;
  logic [isa_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
  logic                     use_rs1, use_rs2;
  isa_pkg::instr_u          instr;
  pipe_pkg::id_ex_t         id_ex_d;

  function automatic logic [isa_pkg::XLEN-1:0] read_reg(input logic [4:0] addr);
    if (addr == 5'd0)
      return '0;
    if (wb_i.reg_write && wb_i.rd == addr)
      return wb_i.data;  // write-through
    return rf[addr];
  endfunction

  function automatic logic [isa_pkg::XLEN-1:0] pick(input pipe_pkg::fwd_sel_e sel,
                                                    input logic [isa_pkg::XLEN-1:0] file_val);
    case (sel)
      pipe_pkg::FWD_EX:  return ex_fwd_i;
      pipe_pkg::FWD_MEM: return mem_fwd_i;
      default:           return file_val;
    endcase
  endfunction

  function automatic isa_pkg::alu_op_e alu_of(input logic [2:0] f3);
    case (f3)
      isa_pkg::F3_SLT: return isa_pkg::ALU_SLT;
      isa_pkg::F3_XOR: return isa_pkg::ALU_XOR;
      isa_pkg::F3_OR:  return isa_pkg::ALU_OR;
      isa_pkg::F3_AND: return isa_pkg::ALU_AND;
      default:         return isa_pkg::ALU_ADD;
    endcase
  endfunction

  assign instr = if_id_i.instr;

  // s, b and j fields come out of the r view
  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_s = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
  assign imm_b = {{20{instr.r.funct7[6]}}, instr.r.rd[0], instr.r.funct7[5:0],
                  instr.r.rd[4:1], 1'b0};
  assign imm_j = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
                  instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

  always_comb begin
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (instr.r.opcode)
      isa_pkg::OP, isa_pkg::STORE, isa_pkg::BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      isa_pkg::OP_IMM, isa_pkg::LOAD: use_rs1 = 1'b1;
      default: ;
    endcase
  end

  // unused sources report x0 so they never stall or forward
  assign rs1_o = use_rs1 ? instr.r.rs1 : 5'd0;
  assign rs2_o = use_rs2 ? instr.r.rs2 : 5'd0;

  always_comb rs1_val = pick(fwd_a_i, read_reg(rs1_o));
  always_comb rs2_val = pick(fwd_b_i, read_reg(rs2_o));

  assign target_o = if_id_i.pc + ((instr.r.opcode == isa_pkg::JAL) ? imm_j : imm_b);

  always_comb begin
    id_ex_d            = '0;
    id_ex_d.opr_a      = rs1_val;
    id_ex_d.opr_b      = rs2_val;
    id_ex_d.store_data = rs2_val;
    id_ex_d.alu_op     = alu_of(instr.r.funct3);
    id_ex_d.rd         = instr.r.rd;
    id_ex_d.link_pc    = if_id_i.pc + 32'd4;
    branch_taken_o     = 1'b0;
    is_jump_o          = 1'b0;
    case (instr.r.opcode)
      isa_pkg::OP: begin
        id_ex_d.reg_write = 1'b1;
        if (instr.r.funct3 == isa_pkg::F3_ADD_SUB && instr.r.funct7 == isa_pkg::F7_SUB)
          id_ex_d.alu_op = isa_pkg::ALU_SUB;
      end
      isa_pkg::OP_IMM: begin
        id_ex_d.reg_write = 1'b1;
        id_ex_d.opr_b     = imm_i;
      end
      isa_pkg::LOAD: begin
        id_ex_d.reg_write = 1'b1;
        id_ex_d.mem_read  = 1'b1;
        id_ex_d.opr_b     = imm_i;
        id_ex_d.alu_op    = isa_pkg::ALU_ADD;
      end
      isa_pkg::STORE: begin
        id_ex_d.mem_write = 1'b1;
        id_ex_d.opr_b     = imm_s;
        id_ex_d.alu_op    = isa_pkg::ALU_ADD;
      end
      isa_pkg::BRANCH: begin
        if (instr.r.funct3 == isa_pkg::F3_BEQ)
          branch_taken_o = (rs1_val == rs2_val);
        else if (instr.r.funct3 == isa_pkg::F3_BNE)
          branch_taken_o = (rs1_val != rs2_val);
      end
      isa_pkg::JAL: begin
        is_jump_o         = 1'b1;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.link      = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (wb_i.reg_write && wb_i.rd != 5'd0)
      rf[wb_i.rd] <= wb_i.data;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || stall_i) begin
      // bubble
      id_ex_o.reg_write <= 1'b0;
      id_ex_o.mem_read  <= 1'b0;
      id_ex_o.mem_write <= 1'b0;
      id_ex_o.link      <= 1'b0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

//--- rtl/execute_unit.sv
module execute_unit (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  pipe_pkg::id_ex_t         id_ex_i,
  output logic [isa_pkg::XLEN-1:0] alu_result_o,
  output pipe_pkg::ex_mem_t        ex_mem_o
);

  logic [isa_pkg::XLEN-1:0] alu_out;
  logic                     lt;

  assign lt = $signed(id_ex_i.opr_a) < $signed(id_ex_i.opr_b);

  always_comb begin
    case (id_ex_i.alu_op)
      isa_pkg::ALU_SUB: alu_out = id_ex_i.opr_a - id_ex_i.opr_b;
      isa_pkg::ALU_AND: alu_out = id_ex_i.opr_a & id_ex_i.opr_b;
      isa_pkg::ALU_OR:  alu_out = id_ex_i.opr_a | id_ex_i.opr_b;
      isa_pkg::ALU_XOR: alu_out = id_ex_i.opr_a ^ id_ex_i.opr_b;
      isa_pkg::ALU_SLT: alu_out = {{(isa_pkg::XLEN-1){1'b0}}, lt};
      default:          alu_out = id_ex_i.opr_a + id_ex_i.opr_b;
    endcase
  end

  // jal writes its return address
  assign alu_result_o = id_ex_i.link ? id_ex_i.link_pc : alu_out;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_mem_o.reg_write <= 1'b0;
      ex_mem_o.mem_read  <= 1'b0;
      ex_mem_o.mem_write <= 1'b0;
    end else begin
      ex_mem_o.result     <= alu_result_o;
      ex_mem_o.store_data <= id_ex_i.store_data;
      ex_mem_o.rd         <= id_ex_i.rd;
      ex_mem_o.reg_write  <= id_ex_i.reg_write;
      ex_mem_o.mem_read   <= id_ex_i.mem_read;
      ex_mem_o.mem_write  <= id_ex_i.mem_write;
    end
  end

endmodule

//--- rtl/memory_unit.sv
module memory_unit #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  pipe_pkg::ex_mem_t        ex_mem_i,
  output logic [isa_pkg::XLEN-1:0] mem_fwd_o,
  output pipe_pkg::mem_wb_t        wb_o,
  output logic                     retire_valid_o,
  output pipe_pkg::retire_t        retire_o
);

  localparam int AW = $clog2(DMEM_DEPTH);

  logic [isa_pkg::XLEN-1:0] dmem [DMEM_DEPTH];
  logic [AW-1:0]            addr;

  assign addr = ex_mem_i.result[AW+1:2];  // word index

  always_ff @(posedge clk_i) begin
    if (ex_mem_i.mem_write)
      dmem[addr] <= ex_mem_i.store_data;
  end

  // read in mem, captured into mem/wb below
  assign mem_fwd_o = ex_mem_i.mem_read ? dmem[addr] : ex_mem_i.result;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_o.reg_write <= 1'b0;
    end else begin
      wb_o.rd        <= ex_mem_i.rd;
      wb_o.data      <= mem_fwd_o;
      wb_o.reg_write <= ex_mem_i.reg_write;
    end
  end

  assign retire_valid_o = wb_o.reg_write && wb_o.rd != 5'd0;
  assign retire_o.rd    = wb_o.rd;
  assign retire_o.data  = wb_o.data;

endmodule

//--- rtl/core_top.sv
module core_top #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  logic                            imem_we_i,
  input  logic [$clog2(IMEM_DEPTH)-1:0]   imem_addr_i,
  input  logic [isa_pkg::XLEN-1:0]        imem_data_i,
  output logic                            retire_valid_o,
  output pipe_pkg::retire_t               retire_o
);

  pipe_pkg::if_id_t         if_id;
  pipe_pkg::id_ex_t         id_ex;
  pipe_pkg::ex_mem_t        ex_mem;
  pipe_pkg::mem_wb_t        mem_wb;
  pipe_pkg::fwd_sel_e       fwd_a, fwd_b;
  logic [isa_pkg::XLEN-1:0] alu_result;
  logic [isa_pkg::XLEN-1:0] mem_fwd;
  logic [isa_pkg::XLEN-1:0] target;
  logic [4:0]               rs1, rs2;
  logic                     branch_taken, is_jump;
  logic                     stall, flush, pc_redirect;

  fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (start_i),
    .imem_we_i     (imem_we_i),
    .imem_addr_i   (imem_addr_i),
    .imem_data_i   (imem_data_i),
    .stall_i       (stall),
    .flush_i       (flush),
    .pc_redirect_i (pc_redirect),
    .target_i      (target),
    .if_id_o       (if_id)
  );

  decode_unit u_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .if_id_i        (if_id),
    .wb_i           (mem_wb),
    .ex_fwd_i       (alu_result),
    .mem_fwd_i      (mem_fwd),
    .fwd_a_i        (fwd_a),
    .fwd_b_i        (fwd_b),
    .stall_i        (stall),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .branch_taken_o (branch_taken),
    .is_jump_o      (is_jump),
    .target_o       (target),
    .id_ex_o        (id_ex)
  );

  execute_unit u_execute (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .id_ex_i      (id_ex),
    .alu_result_o (alu_result),
    .ex_mem_o     (ex_mem)
  );

  memory_unit #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .ex_mem_i       (ex_mem),
    .mem_fwd_o      (mem_fwd),
    .wb_o           (mem_wb),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  // execute stage producer is whatever sits in id/ex
  hazard_ctrl u_hazard (
    .rs1_i           (rs1),
    .rs2_i           (rs2),
    .ex_rd_i         (id_ex.rd),
    .ex_reg_write_i  (id_ex.reg_write),
    .ex_mem_read_i   (id_ex.mem_read),
    .mem_rd_i        (ex_mem.rd),
    .mem_reg_write_i (ex_mem.reg_write),
    .branch_taken_i  (branch_taken),
    .is_jump_i       (is_jump),
    .fwd_a_o         (fwd_a),
    .fwd_b_o         (fwd_b),
    .stall_o         (stall),
    .flush_o         (flush),
    .pc_redirect_o   (pc_redirect)
  );

endmodule

//--- test/core_sva.sv
module core_sva (
  input logic               clk_i,
  input logic               reset_i,
  input logic [4:0]         rs1_i,
  input logic [4:0]         rs2_i,
  input pipe_pkg::fwd_sel_e fwd_a_o,
  input pipe_pkg::fwd_sel_e fwd_b_o,
  input logic               stall_o,
  input logic               flush_o
);

  // a stalled branch must not redirect
  stall_flush_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(stall_o && flush_o))
    else $error("stall and flush high in the same cycle");

  no_fwd_from_x0_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (rs1_i == 5'd0) |-> (fwd_a_o == pipe_pkg::FWD_NONE))
    else $error("operand a forwarded for source x0");

  no_fwd_from_x0_b: assert property (@(posedge clk_i) disable iff (reset_i)
    (rs2_i == 5'd0) |-> (fwd_b_o == pipe_pkg::FWD_NONE))
    else $error("operand b forwarded for source x0");

endmodule

bind hazard_ctrl core_sva u_sva (
  .clk_i   (core_top.clk_i),
  .reset_i (core_top.reset_i),
  .rs1_i   (rs1_i),
  .rs2_i   (rs2_i),
  .fwd_a_o (fwd_a_o),
  .fwd_b_o (fwd_b_o),
  .stall_o (stall_o),
  .flush_o (flush_o)
);

//--- test/core_tb.sv
module core_tb;

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  typedef struct packed {
    logic [31:0] word;
    logic        retires;
    logic [4:0]  rd;
    logic [31:0] data;
  } prog_entry_t;

  logic                 clk;
  logic                 reset_i;
  logic                 start_i;
  logic                 imem_we_i;
  logic [IMEM_AW-1:0]   imem_addr_i;
  logic [31:0]          imem_data_i;
  logic                 retire_valid_o;
  pipe_pkg::retire_t    retire_o;

  prog_entry_t prog [$];
  string       names [$];
  int          expect_idx [$];
  logic        run_started;
  int          watch_cycles;

  core_top #(
    .IMEM_DEPTH (IMEM_DEPTH),
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_dut (
    .clk_i          (clk),
    .reset_i        (reset_i),
    .start_i        (start_i),
    .imem_we_i      (imem_we_i),
    .imem_addr_i    (imem_addr_i),
    .imem_data_i    (imem_data_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] encode_i(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] encode_b(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] encode_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected)
      report_failure($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic add_step(input logic [31:0] word, input logic retires, input logic [4:0] rd,
                          input logic [31:0] data, input string name);
    prog.push_back({word, retires, rd, data});
    names.push_back(name);
  endtask

  // expected values worked out by hand from RV32I semantics
  task automatic build_program();
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5), 1'b1, 5'd1, 32'd5, "addi x1");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd2, 5'd1, 12'd3), 1'b1, 5'd2, 32'd8, "addi x2");
    add_step(encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 1'b1, 5'd3, 32'd13, "add x3");
    add_step(encode_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 1'b1, 5'd4, 32'd8, "sub x4");
    add_step(encode_r(7'h00, 3'b100, 5'd5, 5'd4, 5'd2), 1'b1, 5'd5, 32'd0, "xor x5");
    add_step(encode_r(7'h00, 3'b111, 5'd6, 5'd3, 5'd2), 1'b1, 5'd6, 32'd8, "and x6");
    add_step(encode_r(7'h00, 3'b110, 5'd7, 5'd3, 5'd2), 1'b1, 5'd7, 32'd13, "or x7");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd8, 5'd0, 12'hff9), 1'b1, 5'd8, 32'hffff_fff9,
             "addi x8 negative");
    add_step(encode_r(7'h00, 3'b010, 5'd9, 5'd8, 5'd1), 1'b1, 5'd9, 32'd1, "slt x9");
    add_step(encode_r(7'h00, 3'b010, 5'd10, 5'd1, 5'd8), 1'b1, 5'd10, 32'd0, "slt x10");
    add_step(encode_s(5'd3, 5'd0, 12'd8), 1'b0, 5'd0, 32'd0, "sw x3");
    add_step(encode_i(OPC_LOAD, 3'b010, 5'd11, 5'd0, 12'd8), 1'b1, 5'd11, 32'd13, "lw x11");
    add_step(encode_r(7'h00, 3'b000, 5'd12, 5'd11, 5'd1), 1'b1, 5'd12, 32'd18, "load-use add");
    add_step(encode_b(3'b001, 5'd12, 5'd0, 13'd8), 1'b0, 5'd0, 32'd0, "bne taken");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd13, 5'd0, 12'd99), 1'b0, 5'd0, 32'd0, "skipped");
    add_step(encode_b(3'b000, 5'd4, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, "beq taken");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd13, 5'd0, 12'd98), 1'b0, 5'd0, 32'd0, "skipped");
    add_step(encode_b(3'b000, 5'd1, 5'd2, 13'd8), 1'b0, 5'd0, 32'd0, "beq not taken");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd14, 5'd0, 12'd7), 1'b1, 5'd14, 32'd7, "addi x14");
    add_step(encode_b(3'b000, 5'd14, 5'd0, 13'd8), 1'b0, 5'd0, 32'd0, "beq fwd not taken");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd15, 5'd14, 12'd1), 1'b1, 5'd15, 32'd8, "fall through");
    add_step(encode_j(5'd16, 21'd8), 1'b1, 5'd16, 32'd88, "jal link");  // pc 84
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd17, 5'd0, 12'd1), 1'b0, 5'd0, 32'd0, "skipped");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd5), 1'b0, 5'd0, 32'd0, "write x0");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd18, 5'd16, 12'd0), 1'b1, 5'd18, 32'd88, "use link");
    add_step(encode_i(OPC_LOAD, 3'b010, 5'd19, 5'd0, 12'd8), 1'b1, 5'd19, 32'd13, "lw x19");
    add_step(encode_b(3'b000, 5'd19, 5'd3, 13'd8), 1'b0, 5'd0, 32'd0, "beq on load");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd20, 5'd0, 12'd1), 1'b0, 5'd0, 32'd0, "skipped");
    add_step(encode_i(OPC_OP_IMM, 3'b000, 5'd21, 5'd19, 12'd2), 1'b1, 5'd21, 32'd15, "after load");
    add_step(encode_j(5'd0, 21'd0), 1'b0, 5'd0, 32'd0, "jal self");  // park here
  endtask

  initial begin
    wait (run_started);
    repeat (watch_cycles) @(posedge clk);
    report_failure("timeout: retires stopped coming before the program finished");
  end

  initial begin
    int          seen;
    prog_entry_t entry;
    reset_i     = 1'b1;
    start_i     = 1'b0;
    imem_we_i   = 1'b0;
    imem_addr_i = '0;
    imem_data_i = '0;
    run_started = 1'b0;
    seen        = 0;
    build_program();
    for (int i = 0; i < prog.size(); i++) begin
      if (prog[i].retires)
        expect_idx.push_back(i);
    end
    watch_cycles = prog.size() * 4 + 40;

    repeat (10) @(negedge clk);
    reset_i = 1'b0;

    for (int i = 0; i < prog.size(); i++) begin
      imem_we_i   = 1'b1;
      imem_addr_i = IMEM_AW'(i);
      imem_data_i = prog[i].word;
      @(negedge clk);
      compare_value("quiet during load", 32'd0, {31'd0, retire_valid_o});
    end
    imem_we_i = 1'b0;
    repeat (5) begin
      @(negedge clk);
      compare_value("quiet before start", 32'd0, {31'd0, retire_valid_o});
    end

    start_i     = 1'b1;
    run_started = 1'b1;
    @(negedge clk);
    start_i = 1'b0;

    while (seen < expect_idx.size()) begin
      @(negedge clk);
      if (retire_valid_o) begin
        entry = prog[expect_idx[seen]];
        compare_value({names[expect_idx[seen]], " rd"}, {27'd0, entry.rd}, {27'd0, retire_o.rd});
        compare_value({names[expect_idx[seen]], " data"}, entry.data, retire_o.data);
        seen++;
      end
    end

    // nothing more may retire once the core parks on its jal
    repeat (16) begin
      @(negedge clk);
      compare_value("no retire after last", 32'd0, {31'd0, retire_valid_o});
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog.f
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/hazard_ctrl.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/memory_unit.sv
rtl/core_top.sv
test/core_sva.sv
test/core_tb.sv

//--- Makefile
TOP := core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
